/* Bender.yml */
package:
  name: rv_pipe_core

sources:
  - include_dirs:
      - common
    files:
      - common/rv_pipe_pkg.sv
      - decode/instr_decoder.sv
      - decode/register_file.sv
      - decode/decode_stage.sv
      - fetch/fetch_stage.sv
      - verilog/execute_stage.sv
      - verilog/rv_pipe_core.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/rv_pipe_core_tb.sv

/* common/rv_pipe_consts.svh */
`ifndef RV_PIPE_CONSTS_SVH
`define RV_PIPE_CONSTS_SVH

// register width of the integer datapath.
`define RV_XLEN 64

// register number and instruction widths.
`define RV_REGNO_W 5
`define RV_INSTR_W 32

// the instruction memory is addressed in words.
`define RV_IMEM_DEPTH 256
`define RV_PC_W 8

`endif

/* common/rv_pipe_pkg.sv */
`default_nettype none

`include "rv_pipe_consts.svh"

package rv_pipe_pkg;

  // ****************************************
  // operation classes
  // ****************************************

  // unknown encodings decode to OP_NOP.
  typedef enum logic [3:0] {
    OP_NOP,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_LUI,
    OP_BEQ,
    OP_BNE,
    OP_HALT
  } op_t;

  // ****************************************
  // stage records
  // ****************************************

  typedef struct packed {
    logic                   valid;
    logic [`RV_PC_W-1:0]    pc;
    logic [`RV_INSTR_W-1:0] instr;
  } fetch_t;

  typedef struct packed {
    op_t                    op;
    logic [`RV_REGNO_W-1:0] rs1_regno;
    logic [`RV_REGNO_W-1:0] rs2_regno;
    logic [`RV_REGNO_W-1:0] rd_regno;
    logic [`RV_XLEN-1:0]    imm;
    logic                   uses_rs1;
    logic                   uses_rs2;
    logic                   writes_rd;
  } decoded_t;

  // decode to execute register.
  typedef struct packed {
    logic                   valid;
    logic [`RV_PC_W-1:0]    pc;
    op_t                    op;
    logic [`RV_REGNO_W-1:0] rd_regno;
    logic [`RV_XLEN-1:0]    rs1_value;
    logic [`RV_XLEN-1:0]    rs2_value;
    logic [`RV_XLEN-1:0]    imm;
    logic                   writes_rd;
  } issue_t;

  typedef struct packed {
    logic                   valid;
    logic [`RV_REGNO_W-1:0] rd_regno;
    logic [`RV_XLEN-1:0]    value;
  } wb_t;

endpackage

`default_nettype wire

/* decode/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_pipe_consts.svh"

module decode_stage (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire rv_pipe_pkg::fetch_t fetch,
  input  wire rv_pipe_pkg::wb_t    wb,
  input  wire logic                redirect,
  output logic                     stall,
  output rv_pipe_pkg::issue_t      issue
);

  rv_pipe_pkg::decoded_t dec;
  logic [`RV_XLEN-1:0]   rs1_value;
  logic [`RV_XLEN-1:0]   rs2_value;
  logic                  rs1_hit;
  logic                  rs2_hit;
  logic                  ex_writes;

  instr_decoder u_instr_decoder (
    .instr (fetch.instr),
    .dec   (dec)
  );

  register_file u_register_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .rs1_regno (dec.rs1_regno),
    .rs2_regno (dec.rs2_regno),
    .wb        (wb),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value)
  );

  // ****************************************
  // hazard check
  // ****************************************

  // a result still in execute is not yet visible to the register file,
  // so the reader waits one cycle and then takes it from the bypass.
  assign ex_writes = issue.valid & issue.writes_rd & (issue.rd_regno != '0);
  assign rs1_hit   = dec.uses_rs1 & (dec.rs1_regno == issue.rd_regno);
  assign rs2_hit   = dec.uses_rs2 & (dec.rs2_regno == issue.rd_regno);
  assign stall     = fetch.valid & ex_writes & (rs1_hit | rs2_hit) & ~redirect;

  // ****************************************
  // decode register
  // ****************************************

  always_ff @(posedge clk) begin
    issue.pc        <= fetch.pc;
    issue.op        <= dec.op;
    issue.rd_regno  <= dec.rd_regno;
    issue.rs1_value <= rs1_value;
    issue.rs2_value <= rs2_value;
    issue.imm       <= dec.imm;
    issue.writes_rd <= dec.writes_rd;
    if (!rst_n) begin
      issue.valid <= 1'b0;
    end else begin
      // a taken branch or a stall leaves a bubble behind.
      issue.valid <= fetch.valid & ~stall & ~redirect;
    end
  end

endmodule

`default_nettype wire

/* decode/instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_pipe_consts.svh"

module instr_decoder (
  input  wire logic [`RV_INSTR_W-1:0] instr,
  output rv_pipe_pkg::decoded_t       dec
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;

  // ****************************************
  // fields and immediates
  // ****************************************

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};

  // the B offset field counts instruction words, so bit 0 of the
  // standard byte encoding is not appended.
  assign imm_b = {{(`RV_XLEN-12){instr[31]}}, instr[31], instr[7],
                  instr[30:25], instr[11:8]};

  // LUI on RV64 sign extends the 32-bit result.
  assign imm_u = {{(`RV_XLEN-32){instr[31]}}, instr[31:12], 12'b0};

  // ****************************************
  // classification
  // ****************************************

  always_comb begin
    dec.op        = rv_pipe_pkg::OP_NOP;
    dec.rs1_regno = instr[19:15];
    dec.rs2_regno = instr[24:20];
    dec.rd_regno  = instr[11:7];
    dec.imm       = '0;
    dec.uses_rs1  = 1'b0;
    dec.uses_rs2  = 1'b0;
    dec.writes_rd = 1'b0;

    case (opcode)
      7'b0110011: begin
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: dec.op = rv_pipe_pkg::OP_ADD;
          {7'b0100000, 3'b000}: dec.op = rv_pipe_pkg::OP_SUB;
          {7'b0000000, 3'b111}: dec.op = rv_pipe_pkg::OP_AND;
          {7'b0000000, 3'b110}: dec.op = rv_pipe_pkg::OP_OR;
          {7'b0000000, 3'b100}: dec.op = rv_pipe_pkg::OP_XOR;
          default:              dec.op = rv_pipe_pkg::OP_NOP;
        endcase
        if (dec.op != rv_pipe_pkg::OP_NOP) begin
          dec.uses_rs1  = 1'b1;
          dec.uses_rs2  = 1'b1;
          dec.writes_rd = 1'b1;
        end
      end
      7'b0010011: begin
        if (funct3 == 3'b000) begin
          dec.op        = rv_pipe_pkg::OP_ADDI;
          dec.imm       = imm_i;
          dec.uses_rs1  = 1'b1;
          dec.writes_rd = 1'b1;
        end
      end
      7'b0110111: begin
        dec.op        = rv_pipe_pkg::OP_LUI;
        dec.imm       = imm_u;
        dec.writes_rd = 1'b1;
      end
      7'b1100011: begin
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          dec.op       = (funct3 == 3'b000) ? rv_pipe_pkg::OP_BEQ : rv_pipe_pkg::OP_BNE;
          dec.imm      = imm_b;
          dec.uses_rs1 = 1'b1;
          dec.uses_rs2 = 1'b1;
        end
      end
      7'b1110011: begin
        // only ECALL is recognized here, and it stops the core.
        if (instr[31:20] == 12'b0 && funct3 == 3'b000) begin
          dec.op = rv_pipe_pkg::OP_HALT;
        end
      end
      default: begin
        dec.op = rv_pipe_pkg::OP_NOP;
      end
    endcase
  end

endmodule

`default_nettype wire

/* decode/register_file.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_pipe_consts.svh"

module register_file (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic [`RV_REGNO_W-1:0] rs1_regno,
  input  wire logic [`RV_REGNO_W-1:0] rs2_regno,
  input  wire rv_pipe_pkg::wb_t       wb,
  output logic [`RV_XLEN-1:0]         rs1_value,
  output logic [`RV_XLEN-1:0]         rs2_value
);

  logic [`RV_XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.rd_regno != '0) begin
      regs[wb.rd_regno] <= wb.value;
    end
  end

  // a register written in this cycle reads as its new value.
  always_comb begin
    if (rs1_regno == '0) begin
      rs1_value = '0;
    end else if (wb.valid && wb.rd_regno == rs1_regno) begin
      rs1_value = wb.value;
    end else begin
      rs1_value = regs[rs1_regno];
    end
    if (rs2_regno == '0) begin
      rs2_value = '0;
    end else if (wb.valid && wb.rd_regno == rs2_regno) begin
      rs2_value = wb.value;
    end else begin
      rs2_value = regs[rs2_regno];
    end
  end

endmodule

`default_nettype wire

/* fetch/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_pipe_consts.svh"

module fetch_stage (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   start,
  input  wire logic                   imem_we,
  input  wire logic [`RV_PC_W-1:0]    imem_addr,
  input  wire logic [`RV_INSTR_W-1:0] imem_data,
  input  wire logic                   stall,
  input  wire logic                   redirect,
  input  wire logic [`RV_PC_W-1:0]    redirect_pc,
  input  wire logic                   halted,
  output rv_pipe_pkg::fetch_t         fetch
);

  logic [`RV_INSTR_W-1:0] imem [`RV_IMEM_DEPTH];
  logic [`RV_PC_W-1:0]    pc;
  logic                   running;
  logic                   fetch_en;

  // the program is written one word per cycle while the core is idle.
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      running <= 1'b0;
    end else if (halted) begin
      running <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
    end
  end

  assign fetch_en = running & ~halted & ~stall & ~redirect;

  // a redirect wins over a stall and drops the word in the fetch register.
  always_ff @(posedge clk) begin
    if (fetch_en) begin
      fetch.pc    <= pc;
      fetch.instr <= imem[pc];
    end
    if (!rst_n) begin
      pc          <= '0;
      fetch.valid <= 1'b0;
    end else if (redirect) begin
      pc          <= redirect_pc;
      fetch.valid <= 1'b0;
    end else if (!running || halted) begin
      fetch.valid <= 1'b0;
    end else if (!stall) begin
      pc          <= pc + 1'b1;
      fetch.valid <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+common
common/rv_pipe_pkg.sv
decode/instr_decoder.sv
decode/register_file.sv
decode/decode_stage.sv
fetch/fetch_stage.sv
verilog/execute_stage.sv
verilog/rv_pipe_core.sv
tests/rv_pipe_core_tb.sv

/* tests/rv_pipe_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_pipe_consts.svh"

module rv_pipe_core_tb;

  localparam int clk_period  = 100;
  localparam int drive_delay = 10;
  // the programs below hold this many words in all.
  localparam int total_prog_words = 85;

  typedef struct packed {
    rv_pipe_pkg::op_t       op;
    logic [`RV_REGNO_W-1:0] rd;
    logic [`RV_REGNO_W-1:0] rs1;
    logic [`RV_REGNO_W-1:0] rs2;
    logic [19:0]            imm;
  } asm_t;

  typedef struct packed {
    logic [`RV_REGNO_W-1:0] regno;
    logic [`RV_XLEN-1:0]    value;
  } write_t;

  logic                   clk;
  logic                   rst_n;
  logic                   start;
  logic                   imem_we;
  logic [`RV_PC_W-1:0]    imem_addr;
  logic [`RV_INSTR_W-1:0] imem_data;
  logic                   wb_valid;
  logic [`RV_REGNO_W-1:0] wb_regno;
  logic [`RV_XLEN-1:0]    wb_value;
  logic                   halted;

  asm_t   prog[$];
  write_t expected[$];
  int     seed = 50;

  rv_pipe_core uut (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(total_prog_words * 10 * clk_period);
    abort_run("watchdog expired before all tests completed");
  end

  // ****************************************
  // reporting and compare tasks
  // ****************************************

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_regno(input string name, input logic [`RV_REGNO_W-1:0] exp,
                             input logic [`RV_REGNO_W-1:0] act);
    if (exp !== act) begin
      abort_run($sformatf("FAIL %s regno: expected x%0d, actual x%0d", name, exp, act));
    end
  endtask

  task automatic check_value(input string name, input logic [`RV_XLEN-1:0] exp,
                             input logic [`RV_XLEN-1:0] act);
    if (exp !== act) begin
      abort_run($sformatf("FAIL %s value: expected %h, actual %h", name, exp, act));
    end
  endtask

  // ****************************************
  // program building and ISA model
  // ****************************************

  task automatic put(input rv_pipe_pkg::op_t op, input int rd, input int rs1, input int rs2,
                     input int imm);
    asm_t a;
    a.op  = op;
    a.rd  = `RV_REGNO_W'(rd);
    a.rs1 = `RV_REGNO_W'(rs1);
    a.rs2 = `RV_REGNO_W'(rs2);
    a.imm = 20'(imm);
    prog.push_back(a);
  endtask

  function automatic logic [`RV_INSTR_W-1:0] assemble(input asm_t a);
    logic [12:0]             b;
    logic [`RV_INSTR_W-1:0] r;
    logic [`RV_INSTR_W-1:0] br;
    // branch offsets count words, so the byte-form field holds twice the offset.
    b  = {a.imm[11:0], 1'b0};
    r  = {7'b0000000, a.rs2, a.rs1, 3'b000, a.rd, 7'b0110011};
    br = {b[12], b[10:5], a.rs2, a.rs1, 3'b000, b[4:1], b[11], 7'b1100011};
    // funct7 and funct3 values are ORed into the base encodings.
    case (a.op)
      rv_pipe_pkg::OP_ADD:  return r;
      rv_pipe_pkg::OP_SUB:  return r | 32'h4000_0000;
      rv_pipe_pkg::OP_AND:  return r | 32'h0000_7000;
      rv_pipe_pkg::OP_OR:   return r | 32'h0000_6000;
      rv_pipe_pkg::OP_XOR:  return r | 32'h0000_4000;
      rv_pipe_pkg::OP_ADDI: return {a.imm[11:0], a.rs1, 3'b000, a.rd, 7'b0010011};
      rv_pipe_pkg::OP_LUI:  return {a.imm, a.rd, 7'b0110111};
      rv_pipe_pkg::OP_BEQ:  return br;
      rv_pipe_pkg::OP_BNE:  return br | 32'h0000_1000;
      rv_pipe_pkg::OP_HALT: return 32'h0000_0073;
      default:              return 32'h0000_0013;
    endcase
  endfunction

  // runs the program in order and lists the register writes it makes.
  task automatic run_model();
    logic [`RV_XLEN-1:0] regs [32];
    logic [`RV_XLEN-1:0] x;
    logic [`RV_XLEN-1:0] y;
    logic [`RV_XLEN-1:0] res;
    asm_t                a;
    int                  pc;
    int                  npc;
    int                  steps;
    logic                stop;
    logic                wr;
    expected.delete();
    foreach (regs[i]) regs[i] = '0;
    pc    = 0;
    steps = 0;
    stop  = 1'b0;
    while (!stop && steps < 1000 && pc >= 0 && pc < prog.size()) begin
      a   = prog[pc];
      x   = regs[a.rs1];
      y   = regs[a.rs2];
      npc = pc + 1;
      wr  = 1'b1;
      case (a.op)
        rv_pipe_pkg::OP_ADD:  res = x + y;
        rv_pipe_pkg::OP_SUB:  res = x - y;
        rv_pipe_pkg::OP_AND:  res = x & y;
        rv_pipe_pkg::OP_OR:   res = x | y;
        rv_pipe_pkg::OP_XOR:  res = x ^ y;
        rv_pipe_pkg::OP_ADDI: res = x + {{(`RV_XLEN-12){a.imm[11]}}, a.imm[11:0]};
        rv_pipe_pkg::OP_LUI:  res = {{(`RV_XLEN-32){a.imm[19]}}, a.imm, 12'b0};
        default:              wr = 1'b0;
      endcase
      if ((a.op == rv_pipe_pkg::OP_BEQ && x == y) || (a.op == rv_pipe_pkg::OP_BNE && x != y)) begin
        npc = pc + $signed(a.imm[11:0]);
      end
      stop = (a.op == rv_pipe_pkg::OP_HALT);
      if (wr && a.rd != 0) begin
        regs[a.rd] = res;
        expected.push_back(write_t'{a.rd, res});
      end
      pc = npc;
      steps++;
    end
  endtask

  // ****************************************
  // DUT driving
  // ****************************************

  task automatic step();
    @(posedge clk);
    #(drive_delay);
  endtask

  task automatic reset_core();
    rst_n   = 1'b0;
    start   = 1'b0;
    imem_we = 1'b0;
    repeat (5) step();
    rst_n = 1'b1;
  endtask

  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) begin
      imem_we   = 1'b1;
      imem_addr = `RV_PC_W'(i);
      imem_data = assemble(prog[i]);
      step();
    end
    imem_we = 1'b0;
  endtask

  task automatic check_beat(input string name, input int idx);
    if (idx >= expected.size()) begin
      abort_run($sformatf("%s: unexpected extra register write to x%0d", name, wb_regno));
    end else begin
      check_regno(name, expected[idx].regno, wb_regno);
      check_value(name, expected[idx].value, wb_value);
    end
  endtask

  task automatic run_program(input string name);
    int beats;
    int cycles;
    beats  = 0;
    cycles = 0;
    run_model();
    reset_core();
    load_program();
    start = 1'b1;
    step();
    start = 1'b0;
    while (!halted && cycles < prog.size() * 10) begin
      step();
      cycles++;
      if (wb_valid) begin
        check_beat(name, beats);
        beats++;
      end
    end
    if (!halted) begin
      abort_run($sformatf("%s: halted did not rise after ECALL", name));
    end else begin
      repeat (5) begin
        step();
        if (wb_valid) begin
          abort_run($sformatf("%s: register write to x%0d after halt", name, wb_regno));
        end
      end
      if (beats != expected.size()) begin
        abort_run($sformatf("%s: only %0d of %0d register writes arrived", name, beats,
                            expected.size()));
      end
    end
  endtask

  // ****************************************
  // directed tests
  // ****************************************

  task automatic test_alu_immediates();
    prog.delete();
    put(rv_pipe_pkg::OP_ADDI, 1, 0, 0, $random(seed) % 2048);
    put(rv_pipe_pkg::OP_ADDI, 2, 0, 0, -300);
    put(rv_pipe_pkg::OP_LUI, 3, 0, 0, $random(seed));
    put(rv_pipe_pkg::OP_LUI, 4, 0, 0, 'h80001);
    put(rv_pipe_pkg::OP_ADD, 5, 1, 2, 0);
    put(rv_pipe_pkg::OP_SUB, 6, 1, 2, 0);
    put(rv_pipe_pkg::OP_AND, 7, 3, 4, 0);
    put(rv_pipe_pkg::OP_OR, 8, 1, 3, 0);
    put(rv_pipe_pkg::OP_XOR, 9, 2, 4, 0);
    put(rv_pipe_pkg::OP_HALT, 0, 0, 0, 0);
    run_program("alu_immediates");
  endtask

  task automatic test_dependence_chain();
    prog.delete();
    put(rv_pipe_pkg::OP_ADDI, 1, 0, 0, 7);
    put(rv_pipe_pkg::OP_ADDI, 1, 1, 0, -3);
    put(rv_pipe_pkg::OP_ADD, 2, 1, 1, 0);
    put(rv_pipe_pkg::OP_SUB, 3, 2, 1, 0);
    put(rv_pipe_pkg::OP_XOR, 4, 3, 2, 0);
    put(rv_pipe_pkg::OP_OR, 5, 4, 1, 0);
    put(rv_pipe_pkg::OP_AND, 6, 5, 4, 0);
    put(rv_pipe_pkg::OP_ADDI, 6, 6, 0, -100);
    put(rv_pipe_pkg::OP_HALT, 0, 0, 0, 0);
    run_program("dependence_chain");
  endtask

  task automatic test_x0();
    prog.delete();
    put(rv_pipe_pkg::OP_ADDI, 0, 0, 0, 5);
    put(rv_pipe_pkg::OP_ADDI, 1, 0, 0, -1);
    put(rv_pipe_pkg::OP_ADD, 0, 1, 1, 0);
    put(rv_pipe_pkg::OP_ADD, 2, 0, 1, 0);
    put(rv_pipe_pkg::OP_LUI, 0, 0, 0, 'h12345);
    put(rv_pipe_pkg::OP_OR, 3, 0, 0, 0);
    put(rv_pipe_pkg::OP_HALT, 0, 0, 0, 0);
    run_program("x0");
  endtask

  task automatic test_branches();
    prog.delete();
    put(rv_pipe_pkg::OP_ADDI, 1, 0, 0, 3);
    put(rv_pipe_pkg::OP_ADDI, 2, 0, 0, 0);
    // the loop body at word 2 counts x1 down to zero.
    put(rv_pipe_pkg::OP_ADDI, 2, 2, 0, 5);
    put(rv_pipe_pkg::OP_ADDI, 1, 1, 0, -1);
    put(rv_pipe_pkg::OP_BNE, 0, 1, 0, -2);
    put(rv_pipe_pkg::OP_BEQ, 0, 1, 0, 3);
    put(rv_pipe_pkg::OP_ADDI, 3, 0, 0, 1);
    put(rv_pipe_pkg::OP_ADDI, 4, 0, 0, 2);
    put(rv_pipe_pkg::OP_BEQ, 0, 2, 0, 2);
    put(rv_pipe_pkg::OP_BNE, 0, 1, 0, 2);
    put(rv_pipe_pkg::OP_ADDI, 5, 0, 0, 9);
    put(rv_pipe_pkg::OP_HALT, 0, 0, 0, 0);
    run_program("branches");
  endtask

  task automatic test_halt();
    prog.delete();
    put(rv_pipe_pkg::OP_ADDI, 1, 0, 0, 11);
    put(rv_pipe_pkg::OP_ADD, 2, 1, 1, 0);
    put(rv_pipe_pkg::OP_HALT, 0, 0, 0, 0);
    put(rv_pipe_pkg::OP_ADDI, 3, 0, 0, 33);
    put(rv_pipe_pkg::OP_ADD, 4, 1, 1, 0);
    put(rv_pipe_pkg::OP_HALT, 0, 0, 0, 0);
    run_program("halt");
  endtask

  task automatic test_random_alu();
    rv_pipe_pkg::op_t op;
    prog.delete();
    for (int i = 0; i < 40; i++) begin
      // OP_ADD through OP_LUI are the ALU members of the enum.
      op = rv_pipe_pkg::op_t'(1 + $unsigned($random(seed)) % 7);
      put(op, $unsigned($random(seed)) % 8, $unsigned($random(seed)) % 8,
          $unsigned($random(seed)) % 8, $random(seed));
    end
    put(rv_pipe_pkg::OP_HALT, 0, 0, 0, 0);
    run_program("random_alu");
  endtask

  initial begin
    rst_n     = 1'b0;
    start     = 1'b0;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    test_alu_immediates();
    test_dependence_chain();
    test_x0();
    test_branches();
    test_halt();
    test_random_alu();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_pipe_consts.svh"

module execute_stage (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire rv_pipe_pkg::issue_t issue,
  output logic                     redirect,
  output logic [`RV_PC_W-1:0]      redirect_pc,
  output logic                     halted,
  output rv_pipe_pkg::wb_t         wb
);

  logic [`RV_XLEN-1:0] result;
  logic                operands_eq;
  logic                taken;
  logic                live;

  // ****************************************
  // ALU and branch resolution
  // ****************************************

  always_comb begin
    case (issue.op)
      rv_pipe_pkg::OP_ADD:  result = issue.rs1_value + issue.rs2_value;
      rv_pipe_pkg::OP_SUB:  result = issue.rs1_value - issue.rs2_value;
      rv_pipe_pkg::OP_AND:  result = issue.rs1_value & issue.rs2_value;
      rv_pipe_pkg::OP_OR:   result = issue.rs1_value | issue.rs2_value;
      rv_pipe_pkg::OP_XOR:  result = issue.rs1_value ^ issue.rs2_value;
      rv_pipe_pkg::OP_ADDI: result = issue.rs1_value + issue.imm;
      rv_pipe_pkg::OP_LUI:  result = issue.imm;
      default:              result = '0;
    endcase
  end

  assign operands_eq = (issue.rs1_value == issue.rs2_value);
  assign taken = ((issue.op == rv_pipe_pkg::OP_BEQ) &  operands_eq) |
                 ((issue.op == rv_pipe_pkg::OP_BNE) & ~operands_eq);

  // nothing that follows a halt may take effect.
  assign live        = issue.valid & ~halted;
  assign redirect    = live & taken;
  assign redirect_pc = issue.pc + issue.imm[`RV_PC_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halted <= 1'b0;
    end else if (live && issue.op == rv_pipe_pkg::OP_HALT) begin
      halted <= 1'b1;
    end
  end

  // ****************************************
  // writeback register
  // ****************************************

  always_ff @(posedge clk) begin
    wb.rd_regno <= issue.rd_regno;
    wb.value    <= result;
    if (!rst_n) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= live & issue.writes_rd & (issue.rd_regno != '0);
    end
  end

endmodule

`default_nettype wire

/* verilog/rv_pipe_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_pipe_consts.svh"

module rv_pipe_core (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   start,
  input  wire logic                   imem_we,
  input  wire logic [`RV_PC_W-1:0]    imem_addr,
  input  wire logic [`RV_INSTR_W-1:0] imem_data,
  output logic                        wb_valid,
  output logic [`RV_REGNO_W-1:0]      wb_regno,
  output logic [`RV_XLEN-1:0]         wb_value,
  output logic                        halted
);

  rv_pipe_pkg::fetch_t fetch;
  rv_pipe_pkg::issue_t issue;
  rv_pipe_pkg::wb_t    wb;
  logic                stall;
  logic                redirect;
  logic [`RV_PC_W-1:0] redirect_pc;

  fetch_stage u_fetch_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halted      (halted),
    .fetch       (fetch)
  );

  decode_stage u_decode_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .fetch    (fetch),
    .wb       (wb),
    .redirect (redirect),
    .stall    (stall),
    .issue    (issue)
  );

  execute_stage u_execute_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue       (issue),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halted      (halted),
    .wb          (wb)
  );

  // the writeback record is also the core's result port.
  assign wb_valid = wb.valid;
  assign wb_regno = wb.rd_regno;
  assign wb_value = wb.value;

endmodule

`default_nettype wire
